// ==== Bender.yml ====
package:
  name: icu

sources:
  # package first, then leaf units, then the top level
  - verilog/icu_pkg.sv
  - verilog/icu_addsub.sv
  - verilog/icu_multiplier.sv
  - verilog/icu_divider.sv
  - verilog/icu_sequencer.sv
  - verilog/icu_top.sv

  - target: test
    files:
      - bench/icu_tb.sv

// ==== bench/icu_tb.sv ====
/*
 * Integer compute unit testbench
 * checks the reset state and an en ignored during a divide, then runs a
 * table of fixed and random requests back to back, comparing result,
 * flag and latency against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

module icu_tb;
  import icu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_FIXED    = 25;
  localparam int NUM_RAND     = 16;
  localparam int NUM_VEC      = NUM_FIXED + NUM_RAND;
  localparam int WAIT_LIMIT   = DIV_LATENCY + 4;   // cycles allowed for one done
  localparam int WATCHDOG_CYCLES = (NUM_VEC + 2) * (DIV_LATENCY + 4) + RESET_CYCLES;

  typedef struct packed {
    icu_op_e        op;
    logic [31:0]    a;
    logic [31:0]    b;
    icu_rsp_t       exp;
  } vec_t;

  logic            clk;
  logic            rst_n;
  logic            en;
  icu_op_e         operation;
  logic [31:0]     op1;
  logic [31:0]     op2;
  logic            done;
  icu_rsp_t        rsp;

  vec_t   tbl [NUM_VEC];
  int     n_vec  = 0;
  int     n_err  = 0;   // failed checks
  int     n_pass = 0;
  int     n_fail = 0;
  integer seed   = 64045;

  icu_top icu_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .operation (operation),
    .op1       (op1),
    .op2       (op2),
    .done      (done),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic icu_rsp_t reference_result(icu_op_e op, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] q64;
    logic [63:0]        r;
    icu_rsp_t           res;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    case (op)
      OP_ADD: r = sa + sb;
      OP_SUB: r = sa - sb;
      OP_MUL: r = sa * sb;
      default: begin
        if (b == 32'd0) begin
          r = '1;  // divide by zero
        end else begin
          q64 = sa / sb;  // truncates toward zero
          r   = {{32{q64[31]}}, q64[31:0]};  // quotient is 32 bits wide
        end
      end
    endcase
    res.result = r;
    if (r == 64'd0)
      res.flag = 2'b00;
    else if (r[63])
      res.flag = 2'b11;
    else
      res.flag = 2'b10;
    return res;
  endfunction

  function automatic int latency_for(icu_op_e op);
    case (op)
      OP_ADD, OP_SUB: return ADD_LATENCY;
      OP_MUL:         return MUL_LATENCY;
      default:        return DIV_LATENCY;
    endcase
  endfunction

  function automatic string op_text(icu_op_e op);
    case (op)
      OP_ADD:  return "add";
      OP_SUB:  return "sub";
      OP_MUL:  return "mul";
      default: return "div";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // table and reporting helpers
  //////////////////////////////////////////////////
  task automatic add_entry(input icu_op_e op, input logic [31:0] a, input logic [31:0] b);
    tbl[n_vec] = '{op: op, a: a, b: b, exp: reference_result(op, a, b)};
    n_vec++;
  endtask

  task automatic build_table();
    int rnd_op;
    int ra;
    int rb;
    add_entry(OP_ADD, 32'h7FFF_FFFF, 32'h7FFF_FFFF);  // carry into bit 32
    add_entry(OP_ADD, 32'h8000_0000, 32'h8000_0000);
    add_entry(OP_ADD, 32'd5, -32'sd5);
    add_entry(OP_ADD, -32'sd3, 32'd1);
    add_entry(OP_SUB, 32'h8000_0000, 32'd1);
    add_entry(OP_SUB, 32'h7FFF_FFFF, 32'h8000_0000);
    add_entry(OP_SUB, 32'd1234, 32'd1234);
    add_entry(OP_SUB, 32'd0, 32'h8000_0000);
    add_entry(OP_MUL, 32'd3, 32'd7);
    add_entry(OP_MUL, -32'sd3, 32'd7);
    add_entry(OP_MUL, 32'd3, -32'sd7);
    add_entry(OP_MUL, -32'sd3, -32'sd7);
    add_entry(OP_MUL, 32'h8000_0000, 32'h8000_0000);
    add_entry(OP_MUL, 32'h7FFF_FFFF, 32'h8000_0000);
    add_entry(OP_MUL, 32'd0, 32'd12345);
    add_entry(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_entry(OP_DIV, 32'd100, 32'd7);
    add_entry(OP_DIV, -32'sd100, 32'd7);
    add_entry(OP_DIV, 32'd100, -32'sd7);
    add_entry(OP_DIV, -32'sd100, -32'sd7);
    add_entry(OP_DIV, 32'd5, 32'd0);
    add_entry(OP_DIV, -32'sd5, 32'd0);  // negative dividend over zero
    add_entry(OP_DIV, 32'd3, 32'd10);
    add_entry(OP_DIV, 32'h8000_0000, 32'd2);
    add_entry(OP_DIV, 32'h7FFF_FFFF, 32'd1);
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd_op = $random(seed);
      ra     = $random(seed);
      rb     = $random(seed);
      if (rnd_op[1:0] == 2'b11)
        rb = rb >>> 20;  // smaller divisors give wider quotients
      add_entry(icu_op_e'(rnd_op[1:0]), ra, rb);
    end
  endtask

  task automatic fail_value(input string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    n_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    n_err++;
  endtask

  task automatic report_test(input int id, input string what, input int errs_before);
    if (n_err == errs_before) begin
      $display("test %0d %s: pass", id, what);
      n_pass++;
    end else begin
      $display("test %0d %s: fail", id, what);
      n_fail++;
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic check_reset_state();
    int errs0;
    errs0 = n_err;
    if (done !== 1'b0)
      fail_value("done is not low after reset");
    if (rsp.result !== '0 || rsp.flag !== FLAG_ZERO)
      fail_value($sformatf("rsp after reset is %h, expected zero", rsp));
    report_test(1, "reset state", errs0);
  endtask

  // second en lands while the divider is busy
  task automatic check_ignored_en();
    int       errs0;
    int       lat;
    int       dones;
    int       first_lat;
    icu_rsp_t got;
    icu_rsp_t exp;
    errs0     = n_err;
    lat       = 0;
    dones     = 0;
    first_lat = 0;
    got       = '0;
    exp       = reference_result(OP_DIV, -32'sd100, 32'd7);
    en = 1'b1;
    operation = OP_DIV;
    op1 = -32'sd100;
    op2 = 32'd7;
    @(posedge clk);
    #2;
    en = 1'b0;
    repeat (DIV_LATENCY + 8) begin
      @(posedge clk);
      #1;
      lat++;
      if (done) begin
        dones++;
        if (dones == 1) begin
          first_lat = lat;
          got       = rsp;
        end
      end
      #1;
      en = (lat == 5);
      if (lat == 5) begin
        operation = OP_ADD;
        op1 = 32'd1;
        op2 = 32'd2;
      end
    end
    if (dones != 1)
      report_problem($sformatf("test 2: expected one done pulse, saw %0d", dones));
    if (dones > 0 && got !== exp)
      fail_value($sformatf("test 2 rsp %h, expected %h", got, exp));
    if (dones > 0 && first_lat != DIV_LATENCY)
      fail_value($sformatf("test 2 latency %0d, expected %0d", first_lat, DIV_LATENCY));
    report_test(2, "en ignored during divide", errs0);
  endtask

  // entered 2 ns after a rising edge, leaves 2 ns after the done edge
  task automatic run_entry(input int idx);
    int errs0;
    int lat;
    int id;
    errs0 = n_err;
    id    = idx + 3;
    en        = 1'b1;
    operation = tbl[idx].op;
    op1       = tbl[idx].a;
    op2       = tbl[idx].b;
    @(posedge clk);
    #2;
    en = 1'b0;
    if (done)
      fail_value($sformatf("test %0d done held longer than one cycle", id));
    lat = 0;
    while (!done && lat < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!done) begin
      report_problem($sformatf("test %0d: no done pulse within %0d cycles", id, WAIT_LIMIT));
    end else begin
      if (rsp !== tbl[idx].exp)
        fail_value($sformatf("test %0d %s %h %h gave %h flag %b, expected %h flag %b",
                             id, op_text(tbl[idx].op), tbl[idx].a, tbl[idx].b,
                             rsp.result, rsp.flag, tbl[idx].exp.result, tbl[idx].exp.flag));
      if (lat != latency_for(tbl[idx].op))
        fail_value($sformatf("test %0d latency %0d, expected %0d",
                             id, lat, latency_for(tbl[idx].op)));
    end
    report_test(id, op_text(tbl[idx].op), errs0);
    #1;  // next en goes out in the done cycle
  endtask

  initial begin
    rst_n     = 1'b0;
    en        = 1'b0;
    operation = OP_ADD;
    op1       = '0;
    op2       = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_reset_state();
    check_ignored_en();
    for (int i = 0; i < NUM_VEC; i++)
      run_entry(i);
    @(posedge clk);
    #1;
    if (done)
      fail_value("done held longer than one cycle after the last test");
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             n_pass + n_fail, n_pass, n_fail, n_err);
    if (n_err == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d ns, the run stalled", WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/icu_pkg.sv
verilog/icu_addsub.sv
verilog/icu_multiplier.sv
verilog/icu_divider.sv
verilog/icu_sequencer.sv
verilog/icu_top.sv
bench/icu_tb.sv

// ==== verilog/icu_addsub.sv ====
/*
 * Add/subtract unit
 * registers a 33-bit signed a+b or a-b one clock after start
 */

`timescale 1ns/1ps
`default_nettype none

module icu_addsub (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  icu_pkg::icu_req_t            req,
  output logic                         valid,
  output logic [icu_pkg::OPERAND_W:0]  sum
);
  import icu_pkg::*;

  logic [OPERAND_W:0] a_ext;
  logic [OPERAND_W:0] b_ext;
  logic [OPERAND_W:0] b_op;

  assign a_ext = {req.a[OPERAND_W-1], req.a};
  assign b_ext = {req.b[OPERAND_W-1], req.b};
  // negate in 33 bits so the minimum operand still flips sign
  assign b_op  = (req.op == OP_SUB) ? (~b_ext + 1'b1) : b_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      valid <= 1'b0;
    else
      valid <= start;  // one cycle behind the start pulse
  end

  always_ff @(posedge clk) begin
    if (start)
      sum <= a_ext + b_op;  // held until the next start
  end

endmodule

`default_nettype wire

// ==== verilog/icu_divider.sv ====
/*
 * Signed restoring divider
 * works on operand magnitudes, one quotient bit per clock, then a
 * final cycle restores the sign so the quotient truncates toward
 * zero; a zero divisor gives a quotient of all ones
 */

`timescale 1ns/1ps
`default_nettype none

module icu_divider (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  logic [icu_pkg::OPERAND_W-1:0]  a,
  input  logic [icu_pkg::OPERAND_W-1:0]  b,
  output logic                           valid,
  output logic [icu_pkg::OPERAND_W-1:0]  quot
);
  import icu_pkg::*;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
  } div_state_t;

  div_state_t           state;
  logic [CNT_W-1:0]     step;
  logic [OPERAND_W-1:0] dvsr;      // divisor magnitude
  logic [OPERAND_W-1:0] quo_sh;    // dividend shifts out, quotient shifts in
  logic [OPERAND_W-1:0] rem;
  logic                 neg_q;
  logic                 by_zero;
  logic [OPERAND_W:0]   rem_sh;
  logic [OPERAND_W+1:0] trial;

  assign rem_sh = {rem, quo_sh[OPERAND_W-1]};
  assign trial  = {1'b0, rem_sh} - {2'b00, dvsr};  // top bit set means borrow

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
      step  <= '0;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (start) begin
        state <= DIV_RUN;
        step  <= '0;
      end else begin
        case (state)
          DIV_RUN: begin
            step <= step + 1'b1;
            if (step == CNT_W'(DIV_STEPS - 1))
              state <= DIV_FIX;
          end
          DIV_FIX: begin
            valid <= 1'b1;
            state <= DIV_IDLE;
          end
          default: state <= DIV_IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (start) begin
      dvsr    <= b[OPERAND_W-1] ? -b : b;
      quo_sh  <= a[OPERAND_W-1] ? -a : a;
      rem     <= '0;
      neg_q   <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
      by_zero <= (b == '0);
    end else if (state == DIV_RUN) begin
      if (!trial[OPERAND_W+1]) begin
        rem    <= trial[OPERAND_W-1:0];  // subtract fits, keep it
        quo_sh <= {quo_sh[OPERAND_W-2:0], 1'b1};
      end else begin
        rem    <= rem_sh[OPERAND_W-1:0]; // restore
        quo_sh <= {quo_sh[OPERAND_W-2:0], 1'b0};
      end
    end else if (state == DIV_FIX) begin
      if (by_zero)
        quot <= '1;
      else
        quot <= neg_q ? -quo_sh : quo_sh;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icu_multiplier.sv ====
/*
 * Signed 32x32 pipelined multiplier
 * stage 1 forms four 16-bit partial products, the following stages
 * add them up; a valid bit moves with each stage so several products
 * can be in flight, and the output register keeps the last one
 */

`timescale 1ns/1ps
`default_nettype none

module icu_multiplier (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  logic [icu_pkg::OPERAND_W-1:0]   a,
  input  logic [icu_pkg::OPERAND_W-1:0]   b,
  output logic                            valid,
  output logic [icu_pkg::RESULT_W-1:0]    product
);
  import icu_pkg::*;

  logic [MUL_STAGES-1:0] stg_vld;

  // split operands: signed upper halves, unsigned lower halves
  logic signed [OPERAND_W/2-1:0] a_hi, b_hi;
  logic [OPERAND_W/2-1:0]        a_lo, b_lo;

  logic signed [OPERAND_W+1:0] s1_ll;          // lo x lo
  logic signed [OPERAND_W:0]   s1_hl, s1_lh;   // cross terms
  logic signed [OPERAND_W-1:0] s1_hh;          // hi x hi
  logic signed [OPERAND_W+1:0] s2_ll, s2_mid;
  logic signed [OPERAND_W-1:0] s2_hh;
  logic signed [RESULT_W-1:0]  s3_lo;
  logic signed [OPERAND_W-1:0] s3_hh;
  logic signed [RESULT_W-1:0]  s4_prod;

  assign a_hi = a[OPERAND_W-1:OPERAND_W/2];
  assign b_hi = b[OPERAND_W-1:OPERAND_W/2];
  assign a_lo = a[OPERAND_W/2-1:0];
  assign b_lo = b[OPERAND_W/2-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_vld <= '0;
      valid   <= 1'b0;
    end else begin
      stg_vld <= {stg_vld[MUL_STAGES-2:0], start};
      valid   <= stg_vld[MUL_STAGES-1];
    end
  end

  //////////////////////////////////////////////////
  // datapath stages
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    s1_ll  <= $signed({1'b0, a_lo}) * $signed({1'b0, b_lo});
    s1_hl  <= a_hi * $signed({1'b0, b_lo});
    s1_lh  <= $signed({1'b0, a_lo}) * b_hi;
    s1_hh  <= a_hi * b_hi;
    s2_ll  <= s1_ll;
    s2_mid <= s1_hl + s1_lh;
    s2_hh  <= s1_hh;
    s3_lo  <= s2_ll + (s2_mid <<< (OPERAND_W/2));  // middle terms weigh 2^16
    s3_hh  <= s2_hh;
    s4_prod <= s3_lo + (s3_hh <<< OPERAND_W);
    if (stg_vld[MUL_STAGES-1])
      product <= s4_prod;
  end

endmodule

`default_nettype wire

// ==== verilog/icu_pkg.sv ====
/*
 * Integer compute unit shared definitions
 * opcodes, widths, unit latencies, flag codes and the
 * request/response structs passed between the blocks
 */

`default_nettype none

package icu_pkg;

  //////////////////////////////////////////////////
  // widths and timing
  //////////////////////////////////////////////////
  localparam int OPERAND_W  = 32;
  localparam int RESULT_W   = 64;
  localparam int MUL_STAGES = 4;
  localparam int DIV_STEPS  = 32;  // one quotient bit per clock
  localparam int CNT_W      = 6;   // holds DIV_STEPS + 1

  // edges from the en sample to the edge that raises done
  localparam int ADD_LATENCY = 2;
  localparam int MUL_LATENCY = MUL_STAGES + 2;
  localparam int DIV_LATENCY = DIV_STEPS + 3;

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_DIV = 2'b11
  } icu_op_e;

  // high bit is nonzero, low bit is negative
  localparam logic [1:0] FLAG_ZERO = 2'b00;
  localparam logic [1:0] FLAG_POS  = 2'b10;
  localparam logic [1:0] FLAG_NEG  = 2'b11;

  typedef struct packed {
    icu_op_e                     op;
    logic signed [OPERAND_W-1:0] a;
    logic signed [OPERAND_W-1:0] b;
  } icu_req_t;

  typedef struct packed {
    logic [RESULT_W-1:0] result;
    logic [1:0]          flag;
  } icu_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/icu_sequencer.sv ====
/*
 * Compute unit sequencer
 * captures a request on en while idle, starts the selected unit,
 * waits for its valid under a latency guard, then registers the
 * sign-extended result, its zero/sign flag and a done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module icu_sequencer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en,
  input  icu_pkg::icu_op_e               operation,
  input  logic [icu_pkg::OPERAND_W-1:0]  op1,
  input  logic [icu_pkg::OPERAND_W-1:0]  op2,
  output icu_pkg::icu_req_t              req,
  output logic                           add_start,
  output logic                           mul_start,
  output logic                           div_start,
  input  logic                           add_valid,
  input  logic                           mul_valid,
  input  logic                           div_valid,
  input  logic [icu_pkg::OPERAND_W:0]    add_sum,
  input  logic [icu_pkg::RESULT_W-1:0]   mul_product,
  input  logic [icu_pkg::OPERAND_W-1:0]  div_quot,
  output logic                           done,
  output icu_pkg::icu_rsp_t              rsp
);
  import icu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ADDSUB,
    MUL,
    DIV
  } state_t;

  state_t              state;
  logic [CNT_W-1:0]    cnt;         // cycles spent busy
  logic                unit_valid;
  logic [RESULT_W-1:0] result_ext;
  logic [1:0]          result_flag;

  //////////////////////////////////////////////////
  // result selection and flag
  //////////////////////////////////////////////////
  always_comb begin
    unit_valid = 1'b0;
    result_ext = '0;
    case (state)
      ADDSUB: begin
        unit_valid = add_valid;
        result_ext = {{(RESULT_W-OPERAND_W-1){add_sum[OPERAND_W]}}, add_sum};
      end
      MUL: begin
        unit_valid = mul_valid;
        result_ext = mul_product;
      end
      DIV: begin
        unit_valid = div_valid;
        result_ext = {{(RESULT_W-OPERAND_W){div_quot[OPERAND_W-1]}}, div_quot};
      end
      default: ;
    endcase
    if (result_ext == '0)
      result_flag = FLAG_ZERO;
    else if (result_ext[RESULT_W-1])
      result_flag = FLAG_NEG;
    else
      result_flag = FLAG_POS;
  end

  // request is only sampled by a unit together with its start
  always_ff @(posedge clk) begin
    if (state == IDLE && en)
      req <= '{op: operation, a: op1, b: op2};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      cnt       <= '0;
      add_start <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
      rsp       <= '{result: '0, flag: FLAG_ZERO};
    end else begin
      add_start <= 1'b0;  // starts and done are single-cycle pulses
      mul_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
      if (state == IDLE) begin
        cnt <= '0;
        if (en) begin
          case (operation)
            OP_ADD, OP_SUB: begin state <= ADDSUB; add_start <= 1'b1; end
            OP_MUL:         begin state <= MUL;    mul_start <= 1'b1; end
            default:        begin state <= DIV;    div_start <= 1'b1; end
          endcase
        end
      end else begin
        cnt <= cnt + 1'b1;
        if (unit_valid) begin
          rsp   <= '{result: result_ext, flag: result_flag};
          done  <= 1'b1;
          state <= IDLE;             // ready for en in the done cycle
        end else if (cnt > DIV_LATENCY) begin
          state <= IDLE;             // unit never answered, give up
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icu_top.sv ====
/*
 * Integer compute unit top level
 * sequencer plus add/subtract, multiply and divide units
 */

`timescale 1ns/1ps
`default_nettype none

module icu_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en,
  input  icu_pkg::icu_op_e               operation,
  input  logic [icu_pkg::OPERAND_W-1:0]  op1,
  input  logic [icu_pkg::OPERAND_W-1:0]  op2,
  output logic                           done,
  output icu_pkg::icu_rsp_t              rsp
);
  import icu_pkg::*;

  icu_req_t              req;
  logic                  add_start, mul_start, div_start;
  logic                  add_valid, mul_valid, div_valid;
  logic [OPERAND_W:0]    add_sum;
  logic [RESULT_W-1:0]   mul_product;
  logic [OPERAND_W-1:0]  div_quot;

  icu_sequencer u_seq (
    .clk, .rst_n, .en, .operation, .op1, .op2,
    .req, .add_start, .mul_start, .div_start,
    .add_valid, .mul_valid, .div_valid,
    .add_sum, .mul_product, .div_quot,
    .done, .rsp
  );

  icu_addsub u_addsub (
    .clk, .rst_n,
    .start (add_start),
    .req   (req),
    .valid (add_valid),
    .sum   (add_sum)
  );

  icu_multiplier u_mul (
    .clk, .rst_n,
    .start   (mul_start),
    .a       (req.a),
    .b       (req.b),
    .valid   (mul_valid),
    .product (mul_product)
  );

  icu_divider u_div (
    .clk, .rst_n,
    .start (div_start),
    .a     (req.a),
    .b     (req.b),
    .valid (div_valid),
    .quot  (div_quot)
  );

endmodule

`default_nettype wire
